// File: rv32_exec.f
+incdir+.
rv32_isa_pkg.sv
rv32_exec_pkg.sv
rv32_decoder.sv
rv32_regfile.sv
rv32_alu.sv
rv32_commit_unit.sv
rv32_exec_top.sv
rv32_exec_checker.sv
tb_rv32_exec.sv

// File: Makefile
TOP       ?= tb_rv32_exec
FILELIST  ?= rv32_exec.f
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir
FLAGS     ?= --binary --timing --timescale 1ns/100ps -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: TOP FILELIST VERILATOR FLAGS OBJ_DIR"

test:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)

// File: tb_rv32_exec.sv
module tb_rv32_exec;
    timeunit 1ns;
    timeprecision 100ps;
    import rv32_isa_pkg::*;
    import rv32_exec_pkg::*;

    logic        clk;
    logic        rst;
    logic        instr_valid;
    logic [31:0] instr;
    logic        retire_valid;
    retire_t     retire;
    logic [31:0] rng;
    logic [31:0] r;
    logic [31:0] s;
    int          issued;
    int          tb_errors;
    int          check_errors;
    int          retired;
    int          wait_cycles;

    rv32_exec_top u_rv32_exec_top (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    rv32_exec_checker u_rv32_exec_checker (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .retire_valid (retire_valid),
        .retire       (retire),
        .errors       (check_errors),
        .retired      (retired)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] v);
        logic [31:0] x;
        x = v ^ (v << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        instr_fields_t f;
        f = '{f7, rs2, rs1, f3, rd, OPC_OP};
        return f;
    endfunction

    function automatic logic [31:0] enc_i(input opcode_e op, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        instr_fields_t f;
        f = '{imm[11:5], imm[4:0], rs1, f3, rd, op};
        return f;
    endfunction

    function automatic logic [31:0] enc_u(input opcode_e op, input logic [4:0] rd,
                                          input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    // mostly x0..x7 so that results feed the next instructions
    function automatic logic [4:0] pick_reg(input logic [7:0] v);
        return (v[7:5] == 3'b111) ? v[4:0] : {2'b00, v[2:0]};
    endfunction

    function automatic logic [31:0] random_instr(input logic [31:0] a, input logic [31:0] b);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        rd  = pick_reg(b[7:0]);
        rs1 = pick_reg(b[15:8]);
        rs2 = pick_reg(b[23:16]);
        f3  = a[6:4];
        case (a[3:0])
            4'd0, 4'd1, 4'd2, 4'd3, 4'd4: begin
                return enc_r((a[7] && (f3 == 3'd0 || f3 == 3'd5)) ? F7_ALT : F7_BASE,
                             f3, rd, rs1, rs2);
            end
            4'd5, 4'd6, 4'd7, 4'd8: begin
                imm = b[31:20];
                if (f3 == 3'd1) imm = {F7_BASE, b[24:20]};
                if (f3 == 3'd5) imm = {a[7] ? F7_ALT : F7_BASE, b[24:20]};
                return enc_i(OPC_OP_IMM, f3, rd, rs1, imm);
            end
            4'd9: return enc_u(OPC_LUI, rd, a[31:12]);
            4'd10: return enc_u(OPC_AUIPC, rd, a[31:12]);
            4'd11, 4'd12: begin
                if (f3[2:1] == 2'b01) f3 = {2'b00, f3[0]};    // 010 and 011 are not branches
                return enc_b(f3, rs1, rs2, {a[31:20], 1'b0});
            end
            4'd13: return enc_j(rd, {a[31:12], 1'b0});
            4'd14: return enc_i(OPC_JALR, F3_JALR, rd, rs1, b[31:20]);
            default: begin
                case (a[9:8])
                    2'd0: return {b[31:7], 7'b0000011};             // load
                    2'd1: return enc_r(7'h01, f3, rd, rs1, rs2);    // multiply
                    2'd2: return {b[31:15], 3'b010, b[11:7], OPC_BRANCH};
                    default: return enc_i(OPC_JALR, {1'b1, f3[1:0]}, rd, rs1, b[31:20]);
                endcase
            end
        endcase
    endfunction

    task automatic issue(input logic [31:0] w);
        instr_valid = 1'b1;
        instr       = w;
        issued++;
        @(negedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #2000000;
        $display("run stopped after 20000 clock cycles without reaching the end");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        rng         = 32'h21d335d7;
        issued      = 0;
        tb_errors   = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (3) @(negedge clk);                                // no pulse while idle
        issue(enc_r(F7_BASE, F3_OR, 5'd5, 5'd6, 5'd7));           // reads zero after reset
        issue(enc_u(OPC_LUI, 5'd1, 20'h80000));                   // most negative
        issue(enc_i(OPC_OP_IMM, F3_ADD, 5'd2, 5'd1, 12'hfff));    // most positive
        issue(enc_i(OPC_OP_IMM, F3_ADD, 5'd3, 5'd0, 12'hfff));
        issue(enc_i(OPC_OP_IMM, F3_ADD, 5'd4, 5'd0, 12'h001));
        issue(enc_r(F7_BASE, F3_SLT, 5'd5, 5'd1, 5'd2));
        issue(enc_r(F7_BASE, F3_SLTU, 5'd5, 5'd1, 5'd2));
        issue(enc_r(F7_BASE, F3_SLT, 5'd6, 5'd3, 5'd4));
        issue(enc_r(F7_BASE, F3_SLTU, 5'd6, 5'd3, 5'd4));
        issue(enc_i(OPC_OP_IMM, F3_SLTU, 5'd7, 5'd4, 12'hfff));
        issue(enc_r(F7_ALT, F3_ADD, 5'd5, 5'd0, 5'd1));           // wraps back to itself
        issue(enc_r(F7_BASE, F3_ADD, 5'd6, 5'd3, 5'd4));          // carry out, zero sum
        issue(enc_r(F7_ALT, F3_SRL, 5'd7, 5'd1, 5'd3));
        issue(enc_b(F3_BEQ, 5'd1, 5'd1, 13'h0010));
        issue(enc_b(F3_BNE, 5'd1, 5'd1, 13'h0010));
        issue(enc_b(F3_BLT, 5'd1, 5'd2, 13'h1ff0));
        issue(enc_b(F3_BGE, 5'd1, 5'd2, 13'h0020));
        issue(enc_b(F3_BLTU, 5'd1, 5'd2, 13'h0008));
        issue(enc_b(F3_BGEU, 5'd3, 5'd4, 13'h0008));
        issue(enc_b(F3_BGEU, 5'd6, 5'd0, 13'h0004));
        issue(enc_u(OPC_AUIPC, 5'd5, 20'h12345));
        issue(enc_u(OPC_LUI, 5'd0, 20'habcde));                   // x0 keeps its zero
        issue(enc_r(F7_BASE, F3_ADD, 5'd6, 5'd0, 5'd5));
        issue(enc_j(5'd1, 21'h1ff800));
        issue(enc_i(OPC_JALR, F3_JALR, 5'd7, 5'd3, 12'h004));     // odd target
        issue(32'h0000_0003);
        issue(enc_r(7'h01, F3_ADD, 5'd5, 5'd1, 5'd2));
        for (int n = 0; n < 600; n++) begin
            rng = xorshift32(rng);
            if (rng[31:28] == 4'h0) begin
                instr_valid = 1'b0;
                @(negedge clk);
            end
            r   = xorshift32(rng);
            s   = xorshift32(r);
            rng = s;
            issue(random_instr(r, s));
        end
        instr_valid = 1'b0;
        wait_cycles = 0;
        while (retired != issued && wait_cycles < 20) begin
            @(posedge clk);
            wait_cycles++;
        end
        @(posedge clk);
        if (retired != issued) begin
            $display("only %0d of %0d instructions retired", retired, issued);
            tb_errors++;
        end
        $display("errors: %0d from the checker, %0d in the testbench, %0d instructions retired",
                 check_errors, tb_errors, retired);
        if (check_errors == 0 && tb_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: rv32_exec_checker.sv
`include "rv32_exec_settings.svh"

module rv32_exec_checker (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   instr_valid,
    input  logic [31:0]            instr,
    input  logic                   retire_valid,
    input  rv32_exec_pkg::retire_t retire,
    output int                     errors,
    output int                     retired
);
    timeunit 1ns;
    timeprecision 100ps;
    import rv32_isa_pkg::*;
    import rv32_exec_pkg::*;

    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];
    logic [`RV_XLEN-1:0] pc;
    instr_fields_t       fields;
    retire_t             expected;
    logic [31:0]         last_word;
    logic                pending;
    logic                live;

    assign fields = instr;

    // expected retire record computed from the ISA rules
    function automatic retire_t predict_retire(input logic [31:0] w, input logic [31:0] pc_now,
                                               input logic [31:0] rs1_val,
                                               input logic [31:0] rs2_val);
        instr_fields_t f;
        retire_t       r;
        logic [31:0]   imm_i;
        logic [31:0]   imm_u;
        logic [31:0]   imm_b;
        logic [31:0]   imm_j;
        logic [31:0]   opb;
        logic          legal;
        f      = w;
        imm_i  = {{20{w[31]}}, w[31:20]};
        imm_u  = {w[31:12], 12'd0};
        imm_b  = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        imm_j  = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        r      = '0;
        r.pc   = pc_now;
        r.rd   = f.rd;
        r.next_pc = pc_now + 32'd4;
        legal  = 1'b1;
        case (f.opcode)
            OPC_OP, OPC_OP_IMM: begin
                opb     = (f.opcode == OPC_OP) ? rs2_val : imm_i;
                r.wb_en = 1'b1;
                if (f.opcode == OPC_OP) begin
                    legal = (f.funct7 == F7_BASE) ||
                            (f.funct7 == F7_ALT && (f.funct3 == 3'd0 || f.funct3 == 3'd5));
                end else if (f.funct3 == 3'd1) begin
                    legal = (f.funct7 == F7_BASE);
                end else if (f.funct3 == 3'd5) begin
                    legal = (f.funct7 == F7_BASE) || (f.funct7 == F7_ALT);
                end
                case (f.funct3)
                    3'd0: begin
                        if (f.opcode == OPC_OP && f.funct7[5]) r.wb_data = rs1_val - opb;
                        else r.wb_data = rs1_val + opb;
                    end
                    3'd1: r.wb_data = rs1_val << opb[4:0];
                    3'd2: r.wb_data = {31'd0, $signed(rs1_val) < $signed(opb)};
                    3'd3: r.wb_data = {31'd0, rs1_val < opb};
                    3'd4: r.wb_data = rs1_val ^ opb;
                    3'd5: begin
                        if (f.funct7[5]) r.wb_data = $signed(rs1_val) >>> opb[4:0];
                        else r.wb_data = rs1_val >> opb[4:0];
                    end
                    3'd6: r.wb_data = rs1_val | opb;
                    default: r.wb_data = rs1_val & opb;
                endcase
            end
            OPC_LUI: begin
                r.wb_en   = 1'b1;
                r.wb_data = imm_u;
            end
            OPC_AUIPC: begin
                r.wb_en   = 1'b1;
                r.wb_data = pc_now + imm_u;
            end
            OPC_BRANCH: begin
                case (f.funct3)
                    3'd0: r.taken = (rs1_val == rs2_val);
                    3'd1: r.taken = (rs1_val != rs2_val);
                    3'd4: r.taken = ($signed(rs1_val) < $signed(rs2_val));
                    3'd5: r.taken = ($signed(rs1_val) >= $signed(rs2_val));
                    3'd6: r.taken = (rs1_val < rs2_val);
                    3'd7: r.taken = (rs1_val >= rs2_val);
                    default: legal = 1'b0;
                endcase
                if (r.taken) r.next_pc = pc_now + imm_b;
            end
            OPC_JAL: begin
                r.wb_en   = 1'b1;
                r.taken   = 1'b1;
                r.wb_data = pc_now + 32'd4;
                r.next_pc = pc_now + imm_j;
            end
            OPC_JALR: begin
                legal     = (f.funct3 == 3'd0);
                r.wb_en   = 1'b1;
                r.taken   = 1'b1;
                r.wb_data = pc_now + 32'd4;
                r.next_pc = (rs1_val + imm_i) & 32'hffff_fffe;
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin
            r.wb_en   = 1'b0;
            r.taken   = 1'b0;
            r.illegal = 1'b1;
            r.next_pc = pc_now + 32'd4;
        end
        return r;
    endfunction

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        if (got !== want) begin
            $display("CHECK FAILED at %0t: retire.%s is %h, expected %h (instruction %h)",
                     $time, name, got, want, last_word);
            errors++;
        end
    endtask

    initial begin
        errors  = 0;
        retired = 0;
        live    = 1'b0;
        pending = 1'b0;
    end

    // the model steps on the rising edge where the core takes the strobe
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] = '0;
            end
            pc      = `RV_RESET_PC;
            pending = 1'b0;
            live    = 1'b1;
        end else begin
            pending = instr_valid;
            if (instr_valid) begin
                last_word = instr;
                expected  = predict_retire(instr, pc, regs[fields.rs1], regs[fields.rs2]);
                if (expected.wb_en && expected.rd != 5'd0) begin
                    regs[expected.rd] = expected.wb_data;
                end
                pc = expected.next_pc;
            end
        end
    end

    // retire is registered, so half a cycle later it is settled
    always @(negedge clk) begin
        if (live && pending) begin
            if (retire_valid !== 1'b1) begin
                $display("%0t: no retire pulse one cycle after instruction %h", $time, last_word);
                errors++;
            end else begin
                retired++;
                compare_field("pc", retire.pc, expected.pc);
                compare_field("next_pc", retire.next_pc, expected.next_pc);
                compare_field("wb_en", 32'(retire.wb_en), 32'(expected.wb_en));
                compare_field("taken", 32'(retire.taken), 32'(expected.taken));
                compare_field("illegal", 32'(retire.illegal), 32'(expected.illegal));
                if (expected.wb_en) begin
                    compare_field("rd", 32'(retire.rd), 32'(expected.rd));
                    compare_field("wb_data", retire.wb_data, expected.wb_data);
                end
            end
        end else if (live && retire_valid !== 1'b0) begin
            $display("%0t: retire_valid is high but no instruction was taken a cycle before",
                     $time);
            errors++;
        end
    end

endmodule

// File: rv32_exec_top.sv
`include "rv32_exec_settings.svh"

module rv32_exec_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    instr_valid,
    input  logic [31:0]             instr,
    output logic                    retire_valid,
    output rv32_exec_pkg::retire_t  retire
);
    import rv32_exec_pkg::*;

    dec_ctrl_t           ctrl;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] alu_a;
    logic [`RV_XLEN-1:0] alu_b;
    logic [`RV_XLEN-1:0] alu_result;
    logic                alu_branch;
    logic                we;
    logic [4:0]          waddr;
    logic [`RV_XLEN-1:0] wdata;

    rv32_decoder u_rv32_decoder (
        .instr (instr),
        .ctrl  (ctrl)
    );

    rv32_regfile u_rv32_regfile (
        .clk      (clk),
        .rst      (rst),
        .rs1      (ctrl.rs1),
        .rs2      (ctrl.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (we),
        .waddr    (waddr),
        .wdata    (wdata)
    );

    // AUIPC is the only user of the pc operand
    assign alu_a = (ctrl.a_sel == A_PC)  ? pc       : rs1_data;
    assign alu_b = (ctrl.b_sel == B_IMM) ? ctrl.imm : rs2_data;

    rv32_alu u_rv32_alu (
        .a      (alu_a),
        .b      (alu_b),
        .alu_op (ctrl.alu_op),
        .sub    (ctrl.sub),
        .sign   (ctrl.sign),
        .result (alu_result),
        .branch (alu_branch)
    );

    rv32_commit_unit u_rv32_commit_unit (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .ctrl         (ctrl),
        .rs1_data     (rs1_data),
        .alu_result   (alu_result),
        .branch       (alu_branch),
        .pc           (pc),
        .we           (we),
        .waddr        (waddr),
        .wdata        (wdata),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule

// File: rv32_commit_unit.sv
`include "rv32_exec_settings.svh"

module rv32_commit_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      instr_valid,
    input  rv32_exec_pkg::dec_ctrl_t  ctrl,
    input  logic [`RV_XLEN-1:0]       rs1_data,
    input  logic [`RV_XLEN-1:0]       alu_result,
    input  logic                      branch,
    output logic [`RV_XLEN-1:0]       pc,
    output logic                      we,
    output logic [4:0]                waddr,
    output logic [`RV_XLEN-1:0]       wdata,
    output logic                      retire_valid,
    output rv32_exec_pkg::retire_t    retire
);
    import rv32_exec_pkg::*;

    logic [`RV_XLEN-1:0] link;
    logic [`RV_XLEN-1:0] pc_target;
    logic [`RV_XLEN-1:0] jalr_target;
    logic [`RV_XLEN-1:0] next_pc;
    logic                taken;

    assign link        = pc + `RV_XLEN'd4;
    assign pc_target   = pc + ctrl.imm;                 // branch and JAL
    assign jalr_target = (rs1_data + ctrl.imm) & ~`RV_XLEN'd1;

    assign taken   = ctrl.is_branch ? branch : (ctrl.is_jal | ctrl.is_jalr);
    assign next_pc = !taken       ? link        :
                     ctrl.is_jalr ? jalr_target : pc_target;

    assign we    = instr_valid & ctrl.wb_en;
    assign waddr = ctrl.rd;
    assign wdata = (ctrl.is_jal | ctrl.is_jalr) ? link : alu_result;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc           <= `RV_RESET_PC;
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= instr_valid;                // pulse lasts one cycle
            if (instr_valid) begin
                pc <= next_pc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            retire.pc      <= pc;
            retire.next_pc <= next_pc;
            retire.rd      <= ctrl.rd;
            retire.wb_en   <= ctrl.wb_en;
            retire.wb_data <= wdata;
            retire.taken   <= taken;
            retire.illegal <= ctrl.illegal;
        end
    end

endmodule

// File: rv32_alu.sv
`include "rv32_exec_settings.svh"

module rv32_alu (
    input  logic [`RV_XLEN-1:0]     a,
    input  logic [`RV_XLEN-1:0]     b,
    input  rv32_exec_pkg::alu_op_e  alu_op,
    input  logic                    sub,
    input  logic                    sign,
    output logic [`RV_XLEN-1:0]     result,
    output logic                    branch
);
    import rv32_exec_pkg::*;

    logic [`RV_XLEN-1:0] b_eff;
    logic [`RV_XLEN-1:0] sum;
    logic [`RV_XLEN-1:0] shift_res;
    logic [`RV_XLEN-1:0] logic_res;
    logic                carry;
    logic                overflow;
    logic                zero;
    logic                cmp;

    // subtraction is a + ~b + 1
    assign b_eff = sub ? ~b : b;
    assign {carry, sum} = a + b_eff + {{(`RV_XLEN-1){1'b0}}, sub};

    assign zero     = ~(|sum);
    assign overflow = (a[`RV_XLEN-1] == b_eff[`RV_XLEN-1]) &&
                      (a[`RV_XLEN-1] != sum[`RV_XLEN-1]);

    // no carry out of a - b means a is below b unsigned
    assign cmp = sign ? (overflow ^ sum[`RV_XLEN-1]) : ~carry;

    always_comb begin
        case (alu_op)
            ALU_SLL: shift_res = a << b[4:0];
            ALU_SRL: shift_res = a >> b[4:0];
            ALU_SRA: shift_res = $signed(a) >>> b[4:0];
            default: shift_res = a;
        endcase
    end

    always_comb begin
        case (alu_op)
            ALU_AND: logic_res = a & b;
            ALU_OR:  logic_res = a | b;
            ALU_XOR: logic_res = a ^ b;
            default: logic_res = a;
        endcase
    end

    always_comb begin
        case (alu_op)
            ALU_XOR, ALU_OR, ALU_AND:  result = logic_res;
            ALU_SLL, ALU_SRL, ALU_SRA: result = shift_res;
            ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_SET: begin
                result = {{(`RV_XLEN-1){1'b0}}, cmp};
            end
            default: result = sum;
        endcase
    end

    always_comb begin
        case (alu_op)
            ALU_BEQ: branch = zero;
            ALU_BNE: branch = ~zero;
            ALU_BLT: branch = cmp;
            ALU_BGE: branch = ~cmp;
            default: branch = 1'b0;       // only the four branch codes can be taken
        endcase
    end

endmodule

// File: rv32_regfile.sv
`include "rv32_exec_settings.svh"

module rv32_regfile (
    input  logic                clk,
    input  logic                rst,
    input  logic [4:0]          rs1,
    input  logic [4:0]          rs2,
    output logic [`RV_XLEN-1:0] rs1_data,
    output logic [`RV_XLEN-1:0] rs2_data,
    input  logic                we,
    input  logic [4:0]          waddr,
    input  logic [`RV_XLEN-1:0] wdata
);

    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

    // reads see the array as written at the last edge
    assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;                // x0 stays hard-wired to zero
        end
    end

endmodule

// File: rv32_decoder.sv
module rv32_decoder (
    input  rv32_isa_pkg::instr_fields_t instr,
    output rv32_exec_pkg::dec_ctrl_t    ctrl
);
    import rv32_isa_pkg::*;
    import rv32_exec_pkg::*;

    logic [31:0] word;
    logic [31:0] imm_i;
    logic [31:0] imm_u;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic        is_slt;
    logic        alt_ok;

    assign word  = instr;
    assign imm_i = {{20{word[31]}}, word[31:20]};
    assign imm_u = {word[31:12], 12'b0};
    assign imm_b = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
    assign imm_j = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};

    assign is_slt = (instr.funct3 == F3_SLT) || (instr.funct3 == F3_SLTU);
    assign alt_ok = (instr.funct7 == F7_ALT) &&
                    ((instr.funct3 == F3_SRL) ||
                     (instr.funct3 == F3_ADD && instr.opcode == OPC_OP));

    // alt picks SUB over ADD and SRA over SRL
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            F3_ADD:          arith_op = ALU_ADD;
            F3_SLL:          arith_op = ALU_SLL;
            F3_SLT, F3_SLTU: arith_op = ALU_SET;
            F3_XOR:          arith_op = ALU_XOR;
            F3_SRL:          arith_op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:           arith_op = ALU_OR;
            default:         arith_op = ALU_AND;
        endcase
    endfunction

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = ALU_ADD;
        ctrl.a_sel  = A_RS1;
        ctrl.b_sel  = B_RS2;
        ctrl.rs1    = instr.rs1;
        ctrl.rs2    = instr.rs2;
        ctrl.rd     = instr.rd;
        case (instr.opcode)
            OPC_OP, OPC_OP_IMM: begin
                ctrl.wb_en   = 1'b1;
                ctrl.alu_op  = arith_op(instr.funct3, alt_ok);
                ctrl.sub     = is_slt || (alt_ok && instr.funct3 == F3_ADD);
                ctrl.sign    = (instr.funct3 == F3_SLT);
                ctrl.illegal = (instr.funct7 != F7_BASE) && !alt_ok;
                if (instr.opcode == OPC_OP_IMM) begin
                    ctrl.b_sel = B_IMM;
                    ctrl.imm   = imm_i;
                    // only the shift immediates carry a funct7 field
                    if (instr.funct3 != F3_SLL && instr.funct3 != F3_SRL) begin
                        ctrl.illegal = 1'b0;
                    end
                end
            end
            OPC_LUI: begin
                ctrl.wb_en = 1'b1;
                ctrl.rs1   = 5'd0;     // x0 plus the immediate keeps pc out of it
                ctrl.b_sel = B_IMM;
                ctrl.imm   = imm_u;
            end
            OPC_AUIPC: begin
                ctrl.wb_en = 1'b1;
                ctrl.a_sel = A_PC;
                ctrl.b_sel = B_IMM;
                ctrl.imm   = imm_u;
            end
            OPC_BRANCH: begin
                ctrl.is_branch = 1'b1;
                ctrl.sub       = 1'b1;
                ctrl.imm       = imm_b;
                case (instr.funct3)
                    F3_BEQ:  ctrl.alu_op = ALU_BEQ;
                    F3_BNE:  ctrl.alu_op = ALU_BNE;
                    F3_BLT: begin
                        ctrl.alu_op = ALU_BLT;
                        ctrl.sign   = 1'b1;
                    end
                    F3_BGE: begin
                        ctrl.alu_op = ALU_BGE;
                        ctrl.sign   = 1'b1;
                    end
                    F3_BLTU: ctrl.alu_op = ALU_BLT;
                    F3_BGEU: ctrl.alu_op = ALU_BGE;
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            OPC_JAL: begin
                ctrl.wb_en  = 1'b1;
                ctrl.is_jal = 1'b1;
                ctrl.imm    = imm_j;
            end
            OPC_JALR: begin
                ctrl.wb_en   = 1'b1;
                ctrl.is_jalr = 1'b1;
                ctrl.b_sel   = B_IMM;
                ctrl.imm     = imm_i;
                ctrl.illegal = (instr.funct3 != F3_JALR);
            end
            default: ctrl.illegal = 1'b1;
        endcase
        if (ctrl.illegal) begin
            ctrl.wb_en     = 1'b0;   // illegal words only move the pc on by 4
            ctrl.is_branch = 1'b0;
            ctrl.is_jal    = 1'b0;
            ctrl.is_jalr   = 1'b0;
        end
    end

endmodule

// File: rv32_exec_pkg.sv
`include "rv32_exec_settings.svh"

package rv32_exec_pkg;

    // ALU control codes in the encoding the ALU decodes
    typedef enum logic [3:0] {
        ALU_ADD = 4'b0000,
        ALU_XOR = 4'b0001,
        ALU_OR  = 4'b0010,
        ALU_AND = 4'b0011,
        ALU_SLL = 4'b0100,
        ALU_SRL = 4'b0101,
        ALU_SRA = 4'b0110,
        ALU_BEQ = 4'b1000,
        ALU_BNE = 4'b1001,
        ALU_BLT = 4'b1010,
        ALU_BGE = 4'b1011,
        ALU_SET = 4'b1100
    } alu_op_e;

    typedef enum logic {A_RS1 = 1'b0, A_PC  = 1'b1} a_sel_e;
    typedef enum logic {B_RS2 = 1'b0, B_IMM = 1'b1} b_sel_e;

    typedef struct packed {
        alu_op_e              alu_op;
        logic                 sub;       // invert b and carry in one
        logic                 sign;      // signed compare
        a_sel_e               a_sel;
        b_sel_e               b_sel;
        logic [`RV_XLEN-1:0]  imm;
        logic [4:0]           rs1;
        logic [4:0]           rs2;
        logic [4:0]           rd;
        logic                 wb_en;
        logic                 is_branch;
        logic                 is_jal;
        logic                 is_jalr;
        logic                 illegal;
    } dec_ctrl_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]  pc;
        logic [`RV_XLEN-1:0]  next_pc;
        logic [4:0]           rd;
        logic                 wb_en;
        logic [`RV_XLEN-1:0]  wb_data;
        logic                 taken;
        logic                 illegal;
    } retire_t;

endpackage

// File: rv32_isa_pkg.sv
package rv32_isa_pkg;

    // major opcodes handled by the execute core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    // funct3 of the OP and OP_IMM groups
    typedef enum logic [2:0] {
        F3_ADD  = 3'b000,
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SRL  = 3'b101,
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } funct3_e;

    // branch conditions share the same field, so they reuse the type
    localparam funct3_e F3_BEQ  = funct3_e'(3'b000);
    localparam funct3_e F3_BNE  = funct3_e'(3'b001);
    localparam funct3_e F3_BLT  = funct3_e'(3'b100);
    localparam funct3_e F3_BGE  = funct3_e'(3'b101);
    localparam funct3_e F3_BLTU = funct3_e'(3'b110);
    localparam funct3_e F3_BGEU = funct3_e'(3'b111);

    // JALR only defines funct3 of zero
    localparam funct3_e F3_JALR = funct3_e'(3'b000);

    // funct7 values that select SUB and SRA
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // R-type view of an instruction word from which the other formats are rebuilt
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_fields_t;

endpackage

// File: rv32_exec_settings.svh
`ifndef RV32_EXEC_SETTINGS_SVH
`define RV32_EXEC_SETTINGS_SVH

// data path width of the integer core
`define RV_XLEN 32

// architectural register count, x0 included
`define RV_REG_COUNT 32

// fetch address taken by the pc out of reset
`define RV_RESET_PC 32'h0000_0000

`endif
